// ==== project.f ====
design/dma_pkg.sv
design/dma_ctrl.sv
design/dma_mem.sv
design/dma_fill_out.sv
design/dma_model_top.sv
tests/dma_model_checker.sv
tests/dma_model_tb.sv

// ==== Makefile ====
TOP = dma_model_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f project.f --top-module $(TOP)

obj_dir/V$(TOP): project.f design/*.sv tests/*.sv
	verilator --binary --timing --assert -f project.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== tests/dma_model_tb.sv ====
// Testbench for the main-memory model
// Clock, reset, packet and evict stimulus, shadow memory with reference
// function, fill comparison and watchdog

`timescale 1ns/1ps

module dma_model_tb;

  logic                           clk_i;
  logic                           reset_i;
  dma_pkg::dma_pkt_s              dma_pkt_i;
  logic                           dma_pkt_v_i;
  logic                           dma_pkt_yumi_o;
  logic [dma_pkg::DATA_WIDTH-1:0] fill_data_o;
  logic                           fill_v_o;
  logic                           fill_ready_i = 1'b1;
  logic [dma_pkg::DATA_WIDTH-1:0] evict_data_i;
  logic                           evict_v_i;
  logic                           evict_yumi_o;

  logic [dma_pkg::DATA_WIDTH-1:0] shadow [dma_pkg::MEM_WORDS];
  logic [dma_pkg::DATA_WIDTH-1:0] exp_word;
  logic [dma_pkg::ADDR_WIDTH-1:0] rd_addr;
  logic [dma_pkg::ADDR_WIDTH-1:0] wr_addr;
  int  rd_slot, wr_slot;
  int  reads_done = 0, writes_done = 0;
  int  reads_sent = 0, writes_sent = 0;
  int  cycle = 0, rd_accept_cycle;
  bit  rd_active = 1'b0;
  bit  lat_check = 1'b0;  // Ready held high for the current read
  bit  stall_mode = 1'b0;
  int  order[$];

  dma_model_top dut (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .dma_pkt_i      (dma_pkt_i),
    .dma_pkt_v_i    (dma_pkt_v_i),
    .dma_pkt_yumi_o (dma_pkt_yumi_o),
    .fill_data_o    (fill_data_o),
    .fill_v_o       (fill_v_o),
    .fill_ready_i   (fill_ready_i),
    .evict_data_i   (evict_data_i),
    .evict_v_i      (evict_v_i),
    .evict_yumi_o   (evict_yumi_o)
  );

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) cycle <= cycle + 1;

  always @(posedge clk_i) begin
    fill_ready_i <= stall_mode ? ($urandom_range(3, 0) != 0) : 1'b1;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "Run stopped at the first error");
  endtask

  // Word index from the block bits of the byte address plus the word slot
  function automatic logic [dma_pkg::WORD_IDX_W-1:0] word_index(
      input logic [dma_pkg::ADDR_WIDTH-1:0] addr, input int slot);
    int word_bytes;
    int block_num;
    word_bytes = 1 << dma_pkg::BYTE_OFS_W;
    block_num  = (int'(addr) / (word_bytes * dma_pkg::BLOCK_WORDS))
               % (dma_pkg::MEM_WORDS / dma_pkg::BLOCK_WORDS);
    return dma_pkg::WORD_IDX_W'(block_num * dma_pkg::BLOCK_WORDS + slot);
  endfunction

  function automatic logic [dma_pkg::DATA_WIDTH-1:0] ref_word(
      input logic [dma_pkg::ADDR_WIDTH-1:0] addr, input int slot);
    return shadow[word_index(addr, slot)];
  endfunction

  // Random bits above and below the block field must not matter
  function automatic logic [dma_pkg::ADDR_WIDTH-1:0] block_addr(input int blk);
    return dma_pkg::ADDR_WIDTH'($urandom_range(255, 0) * 256 + blk * 16
                                + $urandom_range(15, 0));
  endfunction

  task automatic send_pkt(input bit wnr, input logic [dma_pkg::ADDR_WIDTH-1:0] addr);
    @(posedge clk_i);
    dma_pkt_v_i              <= 1'b1;
    dma_pkt_i.write_not_read <= wnr;
    dma_pkt_i.addr           <= addr;
    do @(negedge clk_i); while (!dma_pkt_yumi_o);
    @(posedge clk_i);
    dma_pkt_v_i <= 1'b0;
  endtask

  task automatic read_block(input int blk);
    reads_sent++;
    send_pkt(1'b0, block_addr(blk));
    while (reads_done < reads_sent) @(negedge clk_i);
  endtask

  task automatic write_block(input int blk, input bit gaps);
    writes_sent++;
    send_pkt(1'b1, block_addr(blk));
    for (int i = 0; i < dma_pkg::BLOCK_WORDS; i++) begin
      if (gaps) begin
        repeat ($urandom_range(3, 0)) begin
          @(posedge clk_i);
          evict_v_i <= 1'b0;
        end
      end
      @(posedge clk_i);
      evict_v_i    <= 1'b1;
      evict_data_i <= $urandom();
      do @(negedge clk_i); while (!evict_yumi_o);
    end
    @(posedge clk_i);
    evict_v_i <= 1'b0;
    while (writes_done < writes_sent) @(negedge clk_i);
  endtask

  // Bookkeeping and comparison, sampled mid-cycle
  always @(negedge clk_i) begin
    if (!reset_i) begin
      if (dma_pkt_v_i && dma_pkt_yumi_o) begin
        if (dma_pkt_i.write_not_read) begin
          wr_addr = dma_pkt_i.addr;
          wr_slot = 0;
        end else begin
          assert (!rd_active) else fail_run("A read packet was accepted during a read");
          rd_addr         = dma_pkt_i.addr;
          rd_slot         = 0;
          rd_active       = 1'b1;
          rd_accept_cycle = cycle;
          lat_check       = !stall_mode;
        end
      end
      if (evict_v_i && evict_yumi_o) begin
        shadow[word_index(wr_addr, wr_slot)] = evict_data_i;
        wr_slot++;
        if (wr_slot == dma_pkg::BLOCK_WORDS) writes_done++;
      end
      if (fill_v_o && fill_ready_i) begin
        assert (rd_active) else fail_run("A fill word left with no read outstanding");
        exp_word = ref_word(rd_addr, rd_slot);
        assert (fill_data_o == exp_word)
          else fail_run($sformatf(
            "Mismatch at %0t ns: addr 0x%04h word %0d is 0x%08h, expected 0x%08h",
            $time, rd_addr, rd_slot, fill_data_o, exp_word));
        if (lat_check) begin
          assert (cycle == rd_accept_cycle + dma_pkg::READ_DELAY + 3 + rd_slot)
            else fail_run($sformatf("Mismatch at %0t ns: word %0d came %0d cycles after accept",
                                    $time, rd_slot, cycle - rd_accept_cycle));
        end
        rd_slot++;
        if (rd_slot == dma_pkg::BLOCK_WORDS) begin
          rd_active = 1'b0;
          reads_done++;
        end
      end
    end
  end

  initial begin : main
    int j;
    int tmp;
    void'($urandom(28052));
    reset_i      = 1'b1;
    dma_pkt_v_i  = 1'b0;
    dma_pkt_i    = '0;
    evict_v_i    = 1'b0;
    evict_data_i = '0;
    shadow       = '{default: '0};
    for (int i = 0; i < dma_pkg::MEM_WORDS / dma_pkg::BLOCK_WORDS; i++) order.push_back(i);
    for (int i = order.size() - 1; i > 0; i--) begin
      j        = int'($urandom_range(i, 0));
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    repeat (8) @(posedge clk_i);
    reset_i <= 1'b0;

    // Untouched blocks read as zero
    // The second read packet is held off until the first read completes
    reads_sent++;
    send_pkt(1'b0, block_addr(order[12]));
    for (int i = 13; i < 16; i++) read_block(order[i]);
    for (int i = 0; i < 8; i++) write_block(order[i], 1'b0);
    for (int i = 7; i >= 0; i--) read_block(order[i]);

    stall_mode = 1'b1;  // Random fill back-pressure
    for (int i = 0; i < 8; i++) read_block(order[i]);
    stall_mode = 1'b0;

    for (int i = 8; i < 12; i++) write_block(order[i], 1'b1);
    for (int i = 11; i >= 8; i--) read_block(order[i]);

    // Read of one block streams while another block absorbs evicts
    reads_sent++;
    send_pkt(1'b0, block_addr(order[0]));
    write_block(order[12], 1'b1);
    while (reads_done < reads_sent) @(negedge clk_i);
    read_block(order[12]);

    repeat (10) @(posedge clk_i);
    if (reads_done == reads_sent && writes_done == writes_sent && !rd_active && !fill_v_o) begin
      $display(">>> PASS");
      $finish;
    end else begin
      fail_run("The run ended with unfinished packets or a stray fill word");
    end
  end

  initial begin : watchdog
    int budget;
    budget = 39 * (dma_pkg::READ_DELAY + dma_pkg::WRITE_DELAY + 40);  // 39 packets in all
    repeat (budget) @(posedge clk_i);
    fail_run("Timeout: the tests did not finish within their cycle budget");
  end

endmodule

// ==== tests/dma_model_checker.sv ====
// Concurrent handshake and write-delay assertions for the memory model top level
// Bound into dma_model_top

`timescale 1ns/1ps

module dma_model_checker (
  input logic                           clk_i,
  input logic                           reset_i,
  input logic                           pkt_v_i,
  input logic                           pkt_yumi_i,
  input logic [dma_pkg::DATA_WIDTH-1:0] fill_data_i,
  input logic                           fill_v_i,
  input logic                           fill_ready_i,
  input logic                           evict_v_i,
  input logic                           evict_yumi_i,
  input dma_pkg::chan_state_e           wr_state_i
);

  // Held word stays put until the consumer takes it
  assert property (@(posedge clk_i) disable iff (reset_i)
    (fill_v_i && !fill_ready_i) |=> (fill_v_i && $stable(fill_data_i)))
    else $error("fill word changed or vanished while the stream was stalled");

  assert property (@(posedge clk_i) disable iff (reset_i) !pkt_v_i |-> !pkt_yumi_i)
    else $error("packet accepted with no valid packet");

  assert property (@(posedge clk_i) disable iff (reset_i) evict_yumi_i |-> evict_v_i)
    else $error("evict word accepted with no valid word");

  // Write channel spends exactly WRITE_DELAY cycles in DELAY
  assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(wr_state_i == dma_pkg::DELAY)
      |-> ##(dma_pkg::WRITE_DELAY) (wr_state_i == dma_pkg::BUSY))
    else $error("write channel left DELAY after the wrong number of cycles");

endmodule

bind dma_model_top dma_model_checker handshake_chk (
  .clk_i        (clk_i),
  .reset_i      (reset_i),
  .pkt_v_i      (dma_pkt_v_i),
  .pkt_yumi_i   (dma_pkt_yumi_o),
  .fill_data_i  (fill_data_o),
  .fill_v_i     (fill_v_o),
  .fill_ready_i (fill_ready_i),
  .evict_v_i    (evict_v_i),
  .evict_yumi_i (evict_yumi_o),
  .wr_state_i   (ctrl.wr_state_r)
);

// ==== design/dma_model_top.sv ====
// Top level of the main-memory model
// Controller, word array and fill output register

`timescale 1ns/1ps

module dma_model_top (
  input  logic                           clk_i,
  input  logic                           reset_i,

  // Packet port
  input  dma_pkg::dma_pkt_s              dma_pkt_i,
  input  logic                           dma_pkt_v_i,
  output logic                           dma_pkt_yumi_o,

  // Fill stream toward the cache
  output logic [dma_pkg::DATA_WIDTH-1:0] fill_data_o,
  output logic                           fill_v_o,
  input  logic                           fill_ready_i,

  // Evict stream from the cache
  input  logic [dma_pkg::DATA_WIDTH-1:0] evict_data_i,
  input  logic                           evict_v_i,
  output logic                           evict_yumi_o
);

  dma_pkg::mem_rd_s               mem_rd;
  dma_pkg::mem_wr_s               mem_wr;
  logic [dma_pkg::DATA_WIDTH-1:0] rd_data;
  logic                           rd_v;
  logic                           fill_full;
  logic                           fill_pop;

  dma_ctrl ctrl (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .pkt_i        (dma_pkt_i),
    .pkt_v_i      (dma_pkt_v_i),
    .pkt_yumi_o   (dma_pkt_yumi_o),
    .evict_v_i    (evict_v_i),
    .evict_yumi_o (evict_yumi_o),
    .evict_data_i (evict_data_i),
    .fill_full_i  (fill_full),
    .fill_pop_i   (fill_pop),
    .mem_rd_o     (mem_rd),
    .mem_wr_o     (mem_wr)
  );

  dma_mem mem (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .rd_i      (mem_rd),
    .wr_i      (mem_wr),
    .rd_data_o (rd_data),
    .rd_v_o    (rd_v)
  );

  dma_fill_out fill_out (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .fill_data_i (rd_data),
    .fill_v_i    (rd_v),
    .ready_i     (fill_ready_i),
    .data_o      (fill_data_o),
    .v_o         (fill_v_o),
    .full_o      (fill_full),
    .pop_o       (fill_pop)
  );

endmodule

// ==== design/dma_fill_out.sv ====
// One-entry output register for the fill stream
// Holds its word under back-pressure and flags each transfer

`timescale 1ns/1ps

module dma_fill_out (
  input  logic                           clk_i,
  input  logic                           reset_i,

  input  logic [dma_pkg::DATA_WIDTH-1:0] fill_data_i,
  input  logic                           fill_v_i,
  input  logic                           ready_i,

  output logic [dma_pkg::DATA_WIDTH-1:0] data_o,
  output logic                           v_o,
  output logic                           full_o,
  output logic                           pop_o
);

  logic [dma_pkg::DATA_WIDTH-1:0] data_r;
  logic                           v_r;
  logic                           load;

  assign pop_o  = v_r & ready_i;
  assign load   = fill_v_i & (~v_r | ready_i);  // Room now, or leaving this cycle
  assign full_o = v_r;
  assign v_o    = v_r;
  assign data_o = data_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_r <= 1'b0;
    end else if (load) begin
      v_r <= 1'b1;
    end else if (pop_o) begin
      v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) data_r <= fill_data_i;
  end

endmodule

// ==== design/dma_mem.sv ====
// Word array of the memory model
// Synchronous read with a valid pulse, clocked write, cleared on reset

`timescale 1ns/1ps

module dma_mem (
  input  logic                           clk_i,
  input  logic                           reset_i,

  input  dma_pkg::mem_rd_s               rd_i,
  input  dma_pkg::mem_wr_s               wr_i,

  output logic [dma_pkg::DATA_WIDTH-1:0] rd_data_o,
  output logic                           rd_v_o
);

  logic [dma_pkg::DATA_WIDTH-1:0] mem_r [dma_pkg::MEM_WORDS];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < dma_pkg::MEM_WORDS; i++) begin
        mem_r[i] <= '0;
      end
      rd_v_o <= 1'b0;
    end else begin
      rd_v_o <= rd_i.en;  // Data valid one cycle after the enable
      if (rd_i.en) begin
        rd_data_o <= mem_r[rd_i.idx];  // Old data on a same-index write
      end
      if (wr_i.en) begin
        mem_r[wr_i.idx] <= wr_i.data;
      end
    end
  end

endmodule

// ==== design/dma_ctrl.sv ====
// Read and write channel FSMs of the memory model
// Packet accept, delay and word counters, array read/write requests

`timescale 1ns/1ps

module dma_ctrl (
  input  logic                             clk_i,
  input  logic                             reset_i,

  input  dma_pkg::dma_pkt_s                pkt_i,
  input  logic                             pkt_v_i,
  output logic                             pkt_yumi_o,

  input  logic                             evict_v_i,
  output logic                             evict_yumi_o,
  input  logic [dma_pkg::DATA_WIDTH-1:0]   evict_data_i,

  input  logic                             fill_full_i,
  input  logic                             fill_pop_i,

  output dma_pkg::mem_rd_s                 mem_rd_o,
  output dma_pkg::mem_wr_s                 mem_wr_o
);

  dma_pkg::chan_state_e rd_state_r, rd_state_n;
  dma_pkg::chan_state_e wr_state_r, wr_state_n;

  logic [dma_pkg::BLOCK_NUM_W-1:0] pkt_blk;
  logic [dma_pkg::BLOCK_NUM_W-1:0] rd_blk_r, wr_blk_r;
  logic [dma_pkg::DELAY_CNT_W-1:0] rd_dly_r, wr_dly_r;

  logic [dma_pkg::BLOCK_IDX_W:0]   rd_issue_r;  // MSB set once the whole block is issued
  logic [dma_pkg::BLOCK_IDX_W-1:0] rd_pop_r;
  logic [dma_pkg::BLOCK_IDX_W-1:0] wr_cnt_r;
  logic                            rd_inflight_r;  // Word sitting in the array read stage

  logic rd_accept, wr_accept;
  logic rd_issue, rd_drop, rd_pop;
  logic wr_take;

  assign pkt_blk = pkt_i.addr[dma_pkg::BYTE_OFS_W + dma_pkg::BLOCK_IDX_W +: dma_pkg::BLOCK_NUM_W];

  // A packet is taken only when its own channel is idle
  assign rd_accept  = pkt_v_i & ~pkt_i.write_not_read & (rd_state_r == dma_pkg::WAIT);
  assign wr_accept  = pkt_v_i & pkt_i.write_not_read & (wr_state_r == dma_pkg::WAIT);
  assign pkt_yumi_o = rd_accept | wr_accept;

  // Fetch while the output register has room this cycle
  assign rd_issue = (rd_state_r == dma_pkg::BUSY) & ~rd_issue_r[dma_pkg::BLOCK_IDX_W]
                  & (~fill_full_i | fill_pop_i);
  assign rd_pop   = (rd_state_r == dma_pkg::BUSY) & fill_pop_i;

  // The output register stalled while a fetched word arrived, so that word
  // is not loaded and gets fetched again from the array
  assign rd_drop  = rd_inflight_r & fill_full_i & ~fill_pop_i;

  assign wr_take      = (wr_state_r == dma_pkg::BUSY) & evict_v_i;
  assign evict_yumi_o = wr_take;

  always_comb begin
    mem_rd_o.en  = rd_issue;
    mem_rd_o.idx = {rd_blk_r, rd_issue_r[dma_pkg::BLOCK_IDX_W-1:0]};

    mem_wr_o.en   = wr_take;
    mem_wr_o.idx  = {wr_blk_r, wr_cnt_r};
    mem_wr_o.data = evict_data_i;
  end

  always_comb begin
    rd_state_n = rd_state_r;
    unique case (rd_state_r)
      dma_pkg::WAIT:  if (rd_accept) rd_state_n = dma_pkg::DELAY;
      dma_pkg::DELAY: if (rd_dly_r == dma_pkg::DELAY_CNT_W'(dma_pkg::READ_DELAY - 1))
                        rd_state_n = dma_pkg::BUSY;
      dma_pkg::BUSY:  if (rd_pop && (&rd_pop_r)) rd_state_n = dma_pkg::WAIT;  // Last word out
      default:        rd_state_n = dma_pkg::WAIT;
    endcase
  end

  always_comb begin
    wr_state_n = wr_state_r;
    unique case (wr_state_r)
      dma_pkg::WAIT:  if (wr_accept) wr_state_n = dma_pkg::DELAY;
      dma_pkg::DELAY: if (wr_dly_r == dma_pkg::DELAY_CNT_W'(dma_pkg::WRITE_DELAY - 1))
                        wr_state_n = dma_pkg::BUSY;
      dma_pkg::BUSY:  if (wr_take && (&wr_cnt_r)) wr_state_n = dma_pkg::WAIT;
      default:        wr_state_n = dma_pkg::WAIT;
    endcase
  end

  // Read channel
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_state_r    <= dma_pkg::WAIT;
      rd_dly_r      <= '0;
      rd_issue_r    <= '0;
      rd_pop_r      <= '0;
      rd_inflight_r <= 1'b0;
    end else begin
      rd_state_r    <= rd_state_n;
      rd_inflight_r <= rd_issue;
      if (rd_state_r == dma_pkg::DELAY) rd_dly_r <= rd_dly_r + 1'b1;
      else rd_dly_r <= '0;

      if (rd_accept) begin
        rd_issue_r <= '0;
        rd_pop_r   <= '0;
      end else begin
        if (rd_issue) rd_issue_r <= rd_issue_r + 1'b1;
        else if (rd_drop) rd_issue_r <= rd_issue_r - 1'b1;  // Rewind to the lost word
        if (rd_pop) rd_pop_r <= rd_pop_r + 1'b1;
      end
    end
  end

  // Write channel
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_state_r <= dma_pkg::WAIT;
      wr_dly_r   <= '0;
      wr_cnt_r   <= '0;
    end else begin
      wr_state_r <= wr_state_n;
      if (wr_state_r == dma_pkg::DELAY) wr_dly_r <= wr_dly_r + 1'b1;
      else wr_dly_r <= '0;

      if (wr_accept) wr_cnt_r <= '0;
      else if (wr_take) wr_cnt_r <= wr_cnt_r + 1'b1;
    end
  end

  // Block number of the active packet on each channel
  always_ff @(posedge clk_i) begin
    if (rd_accept) rd_blk_r <= pkt_blk;
    if (wr_accept) wr_blk_r <= pkt_blk;
  end

endmodule

// ==== design/dma_pkg.sv ====
// Shared definitions for the main-memory model:
// geometry, packet and array-port structs, channel states

package dma_pkg;

  localparam int ADDR_WIDTH  = 16;
  localparam int DATA_WIDTH  = 32;
  localparam int BLOCK_WORDS = 4;
  localparam int MEM_WORDS   = 64;

  localparam int READ_DELAY  = 6;  // Cycles in read DELAY
  localparam int WRITE_DELAY = 4;  // Cycles in write DELAY

  localparam int WORD_IDX_W  = $clog2(MEM_WORDS);
  localparam int BYTE_OFS_W  = 2;
  localparam int BLOCK_IDX_W = $clog2(BLOCK_WORDS);  // Word slot within a block
  localparam int BLOCK_NUM_W = WORD_IDX_W - BLOCK_IDX_W;
  localparam int DELAY_CNT_W = $clog2((READ_DELAY > WRITE_DELAY) ? READ_DELAY : WRITE_DELAY);

  // Word index = {addr[BYTE_OFS_W+BLOCK_IDX_W +: BLOCK_NUM_W], word slot}
  // The low block bits of the address are ignored

  typedef struct packed {
    logic                  write_not_read;
    logic [ADDR_WIDTH-1:0] addr;
  } dma_pkt_s;

  typedef struct packed {
    logic                  en;
    logic [WORD_IDX_W-1:0] idx;
  } mem_rd_s;

  typedef struct packed {
    logic                  en;
    logic [WORD_IDX_W-1:0] idx;
    logic [DATA_WIDTH-1:0] data;
  } mem_wr_s;

  typedef enum logic [1:0] {
    WAIT,
    DELAY,
    BUSY
  } chan_state_e;

endpackage
